/* maxflow_pkg.sv */
package maxflow_pkg;

   // task and memory widths
   localparam int unsigned TS_W     = 32;
   localparam int unsigned LOCALE_W = 32;
   localparam int unsigned ARG_W    = 32;
   localparam int unsigned ADDR_W   = 32;
   localparam int unsigned DATA_W   = 32;

   // vertex record is 64 bytes
   localparam int unsigned VERTEX_SHIFT = 6;
   localparam logic [ADDR_W-1:0] VID_EXCESS_OFFSET = 'd0;
   localparam logic [ADDR_W-1:0] VID_HEIGHT_OFFSET = 'd8;
   localparam int unsigned FLOW_SLOT_BASE = 4; // first flow word index in record
   localparam int unsigned SLOT_W = 4;

   localparam logic [ADDR_W-1:0] HDR_BASE_ADDR   = 'd0;
   localparam logic [ADDR_W-1:0] HDR_SOURCE_ADDR = 'd4;
   localparam logic [ADDR_W-1:0] HDR_SINK_ADDR   = 'd8;

   typedef enum logic [2:0] {
      TT_DISCHARGE  = 3'd0,
      TT_GET_HEIGHT = 3'd1,
      TT_PUSH       = 3'd2,
      TT_RECEIVE    = 3'd3,
      TT_BFS        = 3'd4
   } task_type_e;

   typedef enum logic [4:0] {
      S_HDR_RD_BASE, S_HDR_WT_BASE,
      S_HDR_RD_SRC, S_HDR_WT_SRC,
      S_HDR_RD_SINK, S_HDR_WT_SINK,
      S_IDLE,
      S_GH_RD, S_GH_WT,
      S_RX_RD_EXC, S_RX_WT_EXC,
      S_RX_RD_FLOW, S_RX_WT_FLOW,
      S_RX_LOG_FLOW, S_RX_REL_FLOW, S_RX_WR_FLOW,
      S_RX_LOG_EXC, S_RX_REL_EXC, S_RX_WR_EXC,
      S_OUT_REQ, S_OUT_REL
   } engine_state_e;

endpackage

/* task_intake.sv */
`timescale 1ns/100ps

module task_intake (
   input  logic                             clk,
   input  logic                             rstn,
   input  logic                             in_req,
   output logic                             in_ack,
   input  maxflow_pkg::task_type_e          in_ttype,
   input  logic [maxflow_pkg::LOCALE_W-1:0] in_locale,
   input  logic [maxflow_pkg::TS_W-1:0]     in_ts,
   input  logic [maxflow_pkg::ARG_W-1:0]    in_arg0,
   input  logic [maxflow_pkg::ARG_W-1:0]    in_arg1,
   input  logic                             full,
   output logic                             push,
   output maxflow_pkg::task_type_e          push_ttype,
   output logic [maxflow_pkg::LOCALE_W-1:0] push_locale,
   output logic [maxflow_pkg::TS_W-1:0]     push_ts,
   output logic [maxflow_pkg::ARG_W-1:0]    push_arg0,
   output logic [maxflow_pkg::ARG_W-1:0]    push_arg1
);

   typedef enum logic [1:0] {IN_WAIT, IN_PUSH, IN_ACK} intake_state_e;

   intake_state_e state;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= IN_WAIT;
      end else begin
         case (state)
            IN_WAIT: if (in_req) state <= IN_PUSH;
            IN_PUSH: if (!full) state <= IN_ACK; // hold until a slot frees
            default: if (!in_req) state <= IN_WAIT;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == IN_WAIT && in_req) begin
         push_ttype  <= in_ttype;
         push_locale <= in_locale;
         push_ts     <= in_ts;
         push_arg0   <= in_arg0;
         push_arg1   <= in_arg1;
      end
   end

   assign push   = (state == IN_PUSH) && !full;
   assign in_ack = (state == IN_ACK);

endmodule

/* task_fifo.sv */
`timescale 1ns/100ps

module task_fifo #(
   parameter int unsigned DEPTH = 4
) (
   input  logic                             clk,
   input  logic                             rstn,
   input  logic                             push,
   input  maxflow_pkg::task_type_e          push_ttype,
   input  logic [maxflow_pkg::LOCALE_W-1:0] push_locale,
   input  logic [maxflow_pkg::TS_W-1:0]     push_ts,
   input  logic [maxflow_pkg::ARG_W-1:0]    push_arg0,
   input  logic [maxflow_pkg::ARG_W-1:0]    push_arg1,
   output logic                             full,
   input  logic                             pop,
   output logic                             not_empty,
   output maxflow_pkg::task_type_e          head_ttype,
   output logic [maxflow_pkg::LOCALE_W-1:0] head_locale,
   output logic [maxflow_pkg::TS_W-1:0]     head_ts,
   output logic [maxflow_pkg::ARG_W-1:0]    head_arg0,
   output logic [maxflow_pkg::ARG_W-1:0]    head_arg1
);
   import maxflow_pkg::*;

   localparam int unsigned PTR_W = $clog2(DEPTH);

   task_type_e        ttype_q  [DEPTH];
   logic [LOCALE_W-1:0] locale_q [DEPTH];
   logic [TS_W-1:0]   ts_q     [DEPTH];
   logic [ARG_W-1:0]  arg0_q   [DEPTH];
   logic [ARG_W-1:0]  arg1_q   [DEPTH];

   logic [PTR_W-1:0] wr_ptr, rd_ptr;
   logic [PTR_W:0]   count;
   logic             wr_en, rd_en;

   assign full      = (count == (PTR_W+1)'(DEPTH));
   assign not_empty = (count != '0);
   assign wr_en     = push && !full;
   assign rd_en     = pop && not_empty;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1; // wraps, DEPTH is a power of two
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         if (wr_en && !rd_en) count <= count + 1'b1;
         else if (rd_en && !wr_en) count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         ttype_q[wr_ptr]  <= push_ttype;
         locale_q[wr_ptr] <= push_locale;
         ts_q[wr_ptr]     <= push_ts;
         arg0_q[wr_ptr]   <= push_arg0;
         arg1_q[wr_ptr]   <= push_arg1;
      end
   end

   assign head_ttype  = ttype_q[rd_ptr];
   assign head_locale = locale_q[rd_ptr];
   assign head_ts     = ts_q[rd_ptr];
   assign head_arg0   = arg0_q[rd_ptr];
   assign head_arg1   = arg1_q[rd_ptr];

endmodule

/* task_engine.sv */
`timescale 1ns/100ps

module task_engine (
   input  logic                             clk,
   input  logic                             rstn,
   input  logic                             not_empty,
   input  maxflow_pkg::task_type_e          head_ttype,
   input  logic [maxflow_pkg::LOCALE_W-1:0] head_locale,
   input  logic [maxflow_pkg::TS_W-1:0]     head_ts,
   input  logic [maxflow_pkg::ARG_W-1:0]    head_arg0,
   input  logic [maxflow_pkg::ARG_W-1:0]    head_arg1,
   output logic                             pop,
   output logic                             mem_rd,
   output logic                             mem_wr,
   output logic [maxflow_pkg::ADDR_W-1:0]   mem_addr,
   output logic [maxflow_pkg::DATA_W-1:0]   mem_wdata,
   input  logic [maxflow_pkg::DATA_W-1:0]   mem_rdata,
   output logic                             out_req,
   input  logic                             out_ack,
   output maxflow_pkg::task_type_e          out_ttype,
   output logic [maxflow_pkg::LOCALE_W-1:0] out_locale,
   output logic [maxflow_pkg::TS_W-1:0]     out_ts,
   output logic [maxflow_pkg::ARG_W-1:0]    out_arg0,
   output logic [maxflow_pkg::ARG_W-1:0]    out_arg1,
   output logic                             undo_req,
   input  logic                             undo_ack,
   output logic [maxflow_pkg::ADDR_W-1:0]   undo_addr,
   output logic [maxflow_pkg::DATA_W-1:0]   undo_data,
   output logic                             idle
);
   import maxflow_pkg::*;

   engine_state_e state, state_next;

   // graph header, loaded once after reset
   logic [ADDR_W-1:0]   base_vertex_data;
   logic [LOCALE_W-1:0] source_node, sink_node;

   logic [LOCALE_W-1:0] cur_locale;
   logic [TS_W-1:0]     cur_ts;
   logic [ARG_W-1:0]    cur_arg0, cur_arg1;

   logic [DATA_W-1:0] old_excess, old_flow;
   logic [ADDR_W-1:0] vertex_addr, exc_addr, height_addr, flow_addr;
   logic              wake_vertex;

   assign vertex_addr = base_vertex_data + (ADDR_W'(cur_locale) << VERTEX_SHIFT);
   assign exc_addr    = vertex_addr + VID_EXCESS_OFFSET;
   assign height_addr = vertex_addr + VID_HEIGHT_OFFSET;
   assign flow_addr   = vertex_addr +
                        (ADDR_W'(FLOW_SLOT_BASE + cur_arg0[SLOT_W-1:0]) << 2);

   // newly active inner vertex needs a discharge
   assign wake_vertex = (old_excess == '0) && (cur_locale != source_node) &&
                        (cur_locale != sink_node);

   assign pop      = (state == S_IDLE) && not_empty;
   assign idle     = (state == S_IDLE);
   assign out_req  = (state == S_OUT_REQ);
   assign undo_req = (state == S_RX_LOG_FLOW) || (state == S_RX_LOG_EXC);
   assign undo_addr = (state == S_RX_LOG_EXC) ? exc_addr : flow_addr;
   assign undo_data = (state == S_RX_LOG_EXC) ? old_excess : old_flow;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= S_HDR_RD_BASE;
      end else begin
         state <= state_next;
      end
   end

   always_comb begin
      state_next = state;
      mem_rd     = 1'b0;
      mem_wr     = 1'b0;
      mem_addr   = '0;
      mem_wdata  = '0;
      case (state)
         S_HDR_RD_BASE: begin
            mem_rd     = 1'b1;
            mem_addr   = HDR_BASE_ADDR;
            state_next = S_HDR_WT_BASE;
         end
         S_HDR_WT_BASE: state_next = S_HDR_RD_SRC;
         S_HDR_RD_SRC: begin
            mem_rd     = 1'b1;
            mem_addr   = HDR_SOURCE_ADDR;
            state_next = S_HDR_WT_SRC;
         end
         S_HDR_WT_SRC: state_next = S_HDR_RD_SINK;
         S_HDR_RD_SINK: begin
            mem_rd     = 1'b1;
            mem_addr   = HDR_SINK_ADDR;
            state_next = S_HDR_WT_SINK;
         end
         S_HDR_WT_SINK: state_next = S_IDLE;
         S_IDLE: begin
            if (not_empty) begin
               case (head_ttype)
                  TT_GET_HEIGHT: state_next = S_GH_RD;
                  TT_RECEIVE:    state_next = S_RX_RD_EXC;
                  default:       state_next = S_IDLE; // other types are dropped
               endcase
            end
         end
         S_GH_RD: begin
            mem_rd     = 1'b1;
            mem_addr   = height_addr;
            state_next = S_GH_WT;
         end
         S_GH_WT: state_next = S_OUT_REQ;
         S_RX_RD_EXC: begin
            mem_rd     = 1'b1;
            mem_addr   = exc_addr;
            state_next = S_RX_WT_EXC;
         end
         S_RX_WT_EXC: state_next = S_RX_RD_FLOW;
         S_RX_RD_FLOW: begin
            mem_rd     = 1'b1;
            mem_addr   = flow_addr;
            state_next = S_RX_WT_FLOW;
         end
         S_RX_WT_FLOW:  state_next = S_RX_LOG_FLOW;
         S_RX_LOG_FLOW: if (undo_ack) state_next = S_RX_REL_FLOW;
         S_RX_REL_FLOW: if (!undo_ack) state_next = S_RX_WR_FLOW;
         S_RX_WR_FLOW: begin
            mem_wr     = 1'b1;
            mem_addr   = flow_addr;
            mem_wdata  = old_flow - cur_arg1; // residual on the reverse edge
            state_next = S_RX_LOG_EXC;
         end
         S_RX_LOG_EXC: if (undo_ack) state_next = S_RX_REL_EXC;
         S_RX_REL_EXC: if (!undo_ack) state_next = S_RX_WR_EXC;
         S_RX_WR_EXC: begin
            mem_wr     = 1'b1;
            mem_addr   = exc_addr;
            mem_wdata  = old_excess + cur_arg1;
            state_next = wake_vertex ? S_OUT_REQ : S_IDLE;
         end
         S_OUT_REQ: if (out_ack) state_next = S_OUT_REL;
         S_OUT_REL: if (!out_ack) state_next = S_IDLE;
         default:   state_next = S_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         cur_locale <= head_locale;
         cur_ts     <= head_ts;
         cur_arg0   <= head_arg0;
         cur_arg1   <= head_arg1;
      end
      case (state)
         S_HDR_WT_BASE: base_vertex_data <= mem_rdata;
         S_HDR_WT_SRC:  source_node <= mem_rdata;
         S_HDR_WT_SINK: sink_node <= mem_rdata;
         S_RX_WT_EXC:   old_excess <= mem_rdata;
         S_RX_WT_FLOW:  old_flow <= mem_rdata;
         S_GH_WT: begin
            out_ttype  <= TT_PUSH;
            out_locale <= cur_arg0; // push goes back to the asking vertex
            out_ts     <= cur_ts;
            out_arg0   <= mem_rdata;
            out_arg1   <= cur_arg1;
         end
         S_RX_WR_EXC: begin
            out_ttype  <= TT_DISCHARGE;
            out_locale <= cur_locale;
            out_ts     <= cur_ts;
            out_arg0   <= '0;
            out_arg1   <= cur_ts;
         end
         default: ;
      endcase
   end

endmodule

/* maxflow_core.sv */
`timescale 1ns/100ps

module maxflow_core (
   input  logic                             clk,
   input  logic                             rstn,
   input  logic                             in_req,
   output logic                             in_ack,
   input  maxflow_pkg::task_type_e          in_ttype,
   input  logic [maxflow_pkg::LOCALE_W-1:0] in_locale,
   input  logic [maxflow_pkg::TS_W-1:0]     in_ts,
   input  logic [maxflow_pkg::ARG_W-1:0]    in_arg0,
   input  logic [maxflow_pkg::ARG_W-1:0]    in_arg1,
   output logic                             out_req,
   input  logic                             out_ack,
   output maxflow_pkg::task_type_e          out_ttype,
   output logic [maxflow_pkg::LOCALE_W-1:0] out_locale,
   output logic [maxflow_pkg::TS_W-1:0]     out_ts,
   output logic [maxflow_pkg::ARG_W-1:0]    out_arg0,
   output logic [maxflow_pkg::ARG_W-1:0]    out_arg1,
   output logic                             undo_req,
   input  logic                             undo_ack,
   output logic [maxflow_pkg::ADDR_W-1:0]   undo_addr,
   output logic [maxflow_pkg::DATA_W-1:0]   undo_data,
   output logic                             mem_rd,
   output logic                             mem_wr,
   output logic [maxflow_pkg::ADDR_W-1:0]   mem_addr,
   output logic [maxflow_pkg::DATA_W-1:0]   mem_wdata,
   input  logic [maxflow_pkg::DATA_W-1:0]   mem_rdata,
   output logic                             idle
);
   import maxflow_pkg::*;

   logic                push, full, pop, not_empty;
   task_type_e          push_ttype, head_ttype;
   logic [LOCALE_W-1:0] push_locale, head_locale;
   logic [TS_W-1:0]     push_ts, head_ts;
   logic [ARG_W-1:0]    push_arg0, push_arg1, head_arg0, head_arg1;

   task_intake u_intake (
      .clk, .rstn, .in_req, .in_ack, .in_ttype, .in_locale, .in_ts, .in_arg0, .in_arg1,
      .full, .push, .push_ttype, .push_locale, .push_ts, .push_arg0, .push_arg1
   );

   task_fifo #(.DEPTH(4)) u_fifo (
      .clk, .rstn, .push, .push_ttype, .push_locale, .push_ts, .push_arg0, .push_arg1,
      .full, .pop, .not_empty,
      .head_ttype, .head_locale, .head_ts, .head_arg0, .head_arg1
   );

   task_engine u_engine (
      .clk, .rstn, .not_empty,
      .head_ttype, .head_locale, .head_ts, .head_arg0, .head_arg1, .pop,
      .mem_rd, .mem_wr, .mem_addr, .mem_wdata, .mem_rdata,
      .out_req, .out_ack, .out_ttype, .out_locale, .out_ts, .out_arg0, .out_arg1,
      .undo_req, .undo_ack, .undo_addr, .undo_data,
      .idle
   );

endmodule

/* tb_graph_mem.sv */
`timescale 1ns/100ps

module tb_graph_mem #(
   parameter int unsigned WORDS = 512
) (
   input  logic                           clk,
   input  logic                           rd,
   input  logic                           wr,
   input  logic [maxflow_pkg::ADDR_W-1:0] addr,
   input  logic [maxflow_pkg::DATA_W-1:0] wdata,
   output logic [maxflow_pkg::DATA_W-1:0] rdata
);
   import maxflow_pkg::*;

   logic [DATA_W-1:0] words [WORDS];

   initial begin
      for (int i = 0; i < WORDS; i++) begin
         words[i] = 32'hdead_0000 ^ (i << 2); // byte address in the low half
      end
   end

   // byte address, word storage, one-cycle read latency
   always @(posedge clk) begin
      if (wr) words[addr[ADDR_W-1:2] % WORDS] <= wdata;
      if (rd) rdata <= words[addr[ADDR_W-1:2] % WORDS];
   end

endmodule

/* tb_maxflow_core.sv */
`timescale 1ns/100ps

module tb_maxflow_core;
   import maxflow_pkg::*;

   localparam int unsigned NUM_TESTS = 5;
   localparam logic [31:0] BASE      = 256;
   localparam logic [31:0] SOURCE    = 1;
   localparam logic [31:0] SINK      = 2;

   typedef struct packed {
      task_type_e          ttype;
      logic [LOCALE_W-1:0] locale;
      logic [TS_W-1:0]     ts;
      logic [ARG_W-1:0]    arg0;
      logic [ARG_W-1:0]    arg1;
   } task_rec_t;

   logic                clk = 1'b0;
   logic                rstn, in_req, in_ack, out_req, out_ack, undo_req, undo_ack;
   task_type_e          in_ttype, out_ttype;
   logic [LOCALE_W-1:0] in_locale, out_locale;
   logic [TS_W-1:0]     in_ts, out_ts;
   logic [ARG_W-1:0]    in_arg0, in_arg1, out_arg0, out_arg1;
   logic [ADDR_W-1:0]   undo_addr, mem_addr;
   logic [DATA_W-1:0]   undo_data, mem_wdata, mem_rdata;
   logic                mem_rd, mem_wr, idle;

   task_rec_t                out_now, prev_out;
   task_rec_t                outq [$];
   logic [ADDR_W+DATA_W-1:0] undoq [$];
   logic [ADDR_W+DATA_W-1:0] prev_undo;
   logic prev_out_req, prev_out_ack, prev_undo_req, prev_undo_ack, prev_in_ack;
   logic        saw_full = 1'b0;
   int          wr_count, errors, groups_ok, group_start;
   int          out_delay_max = 3;
   logic [31:0] lcg_state = 77;

   maxflow_core dut (.*);

   tb_graph_mem mem (
      .clk, .rd(mem_rd), .wr(mem_wr), .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
   );

   assign out_now = '{out_ttype, out_locale, out_ts, out_arg0, out_arg1};

   always #5 clk = ~clk;

   function automatic int unsigned lcg_next(int unsigned range);
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[30:16] % range;
   endfunction

   function automatic logic [ADDR_W-1:0] rec_addr(int unsigned v);
      return BASE + (v << VERTEX_SHIFT);
   endfunction

   function automatic logic [ADDR_W-1:0] slot_addr(int unsigned v, int unsigned k);
      return rec_addr(v) + ((FLOW_SLOT_BASE + k) << 2);
   endfunction

   task automatic set_word(logic [ADDR_W-1:0] a, logic [DATA_W-1:0] v);
      mem.words[a >> 2] = v;
   endtask

   function automatic logic [DATA_W-1:0] get_word(logic [ADDR_W-1:0] a);
      return mem.words[a >> 2];
   endfunction

   task automatic check_val(string what, logic [31:0] got, logic [31:0] exp);
      assert (got === exp) else begin
         $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic order_fail(string msg);
      $display("handshake order broken at %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic check_task(int idx, task_rec_t exp);
      assert (idx < outq.size()) else begin
         $display("output task %0d never arrived", idx);
         errors++;
      end
      if (idx < outq.size()) begin
         check_val("out type", outq[idx].ttype, exp.ttype);
         check_val("out locale", outq[idx].locale, exp.locale);
         check_val("out ts", outq[idx].ts, exp.ts);
         check_val("out arg0", outq[idx].arg0, exp.arg0);
         check_val("out arg1", outq[idx].arg1, exp.arg1);
      end
   endtask

   task automatic check_undo(int idx, logic [ADDR_W-1:0] a, logic [DATA_W-1:0] d);
      assert (idx < undoq.size()) else begin
         $display("undo entry %0d never arrived", idx);
         errors++;
      end
      if (idx < undoq.size()) begin
         check_val("undo address", undoq[idx][ADDR_W+DATA_W-1:DATA_W], a);
         check_val("undo data", undoq[idx][DATA_W-1:0], d);
      end
   endtask

   task automatic send_task(task_type_e t, logic [31:0] loc, ts, a0, a1);
      @(posedge clk);
      #1;
      in_ttype  = t;
      in_locale = loc;
      in_ts     = ts;
      in_arg0   = a0;
      in_arg1   = a1;
      in_req    = 1'b1;
      do @(negedge clk); while (!in_ack);
      repeat (1 + lcg_next(3)) @(posedge clk);
      @(posedge clk);
      #1 in_req = 1'b0;
      do @(negedge clk); while (in_ack);
   endtask

   // engine back in its wait state with nothing queued
   task automatic wait_done();
      do @(negedge clk); while (!(idle && !dut.not_empty));
   endtask

   task automatic open_group();
      outq.delete();
      undoq.delete();
      wr_count    = 0;
      group_start = errors;
   endtask

   task automatic close_group(string name);
      if (errors == group_start) begin
         $display("[%s] ok", name);
         groups_ok++;
      end else begin
         $display("[%s] FAILED with %0d errors", name, errors - group_start);
      end
   endtask

   task automatic receive_case(int unsigned v, int unsigned slot, logic [31:0] flow, exc, amt, ts);
      logic [ADDR_W-1:0] fa;
      logic [ADDR_W-1:0] ea;
      logic              wake;
      fa   = slot_addr(v, slot);
      ea   = rec_addr(v) + VID_EXCESS_OFFSET;
      wake = (exc == 0) && (v != SOURCE) && (v != SINK);
      outq.delete();
      undoq.delete();
      wr_count = 0;
      set_word(fa, flow);
      set_word(ea, exc);
      send_task(TT_RECEIVE, v, ts, slot, amt);
      wait_done();
      check_val("undo entries", undoq.size(), 2);
      check_undo(0, fa, flow);
      check_undo(1, ea, exc);
      check_val("flow slot", get_word(fa), flow - amt);
      check_val("excess", get_word(ea), exc + amt);
      check_val("memory writes", wr_count, 2);
      check_val("output tasks", outq.size(), wake ? 1 : 0);
      if (wake) check_task(0, '{TT_DISCHARGE, v, ts, 0, ts});
   endtask

   // four-phase order on all three req/ack pairs
   always @(negedge clk) begin
      if (rstn) begin
         if (mem_wr) wr_count++;
         if (dut.full) saw_full = 1'b1;
         if (out_req && !prev_out_req) assert (!out_ack) else order_fail("out req rose early");
         if (!out_req && prev_out_req) assert (prev_out_ack) else order_fail("out req fell early");
         if (out_req && prev_out_req)
            assert (out_now == prev_out) else order_fail("out task changed under req");
         if (undo_req && !prev_undo_req) assert (!undo_ack) else order_fail("undo req rose early");
         if (!undo_req && prev_undo_req)
            assert (prev_undo_ack) else order_fail("undo req fell early");
         if (undo_req && prev_undo_req)
            assert ({undo_addr, undo_data} == prev_undo) else order_fail("undo entry changed");
         if (in_ack && !prev_in_ack) assert (in_req) else order_fail("in ack rose without req");
         if (!in_ack && prev_in_ack) assert (!in_req) else order_fail("in ack fell under req");
      end
      prev_out_req  = out_req;
      prev_out_ack  = out_ack;
      prev_out      = out_now;
      prev_undo_req = undo_req;
      prev_undo_ack = undo_ack;
      prev_undo     = {undo_addr, undo_data};
      prev_in_ack   = in_ack;
   end

   initial begin
      out_ack = 1'b0;
      forever begin
         @(negedge clk);
         if (out_req) begin
            outq.push_back(out_now);
            repeat (out_delay_max / 2 + lcg_next(out_delay_max / 2 + 1)) @(posedge clk);
            @(posedge clk);
            #1 out_ack = 1'b1;
            do @(negedge clk); while (out_req);
            repeat (out_delay_max / 2 + lcg_next(out_delay_max / 2 + 1)) @(posedge clk);
            @(posedge clk);
            #1 out_ack = 1'b0;
         end
      end
   end

   initial begin
      undo_ack = 1'b0;
      forever begin
         @(negedge clk);
         if (undo_req) begin
            undoq.push_back({undo_addr, undo_data});
            repeat (lcg_next(4)) @(posedge clk);
            @(posedge clk);
            #1 undo_ack = 1'b1;
            do @(negedge clk); while (undo_req);
            repeat (2 + lcg_next(3)) @(posedge clk);
            @(posedge clk);
            #1 undo_ack = 1'b0;
         end
      end
   end

   initial begin
      #(NUM_TESTS * 2000);
      $display("watchdog expired before all checks finished");
      $display("test failed");
      $finish;
   end

   initial begin
      rstn      = 1'b0;
      in_req    = 1'b0;
      in_ttype  = TT_DISCHARGE;
      in_locale = '0;
      in_ts     = '0;
      in_arg0   = '0;
      in_arg1   = '0;
      #2;
      set_word(HDR_BASE_ADDR, BASE);
      set_word(HDR_SOURCE_ADDR, SOURCE);
      set_word(HDR_SINK_ADDR, SINK);
      repeat (5) @(posedge clk);
      #1 rstn = 1'b1;
      do @(negedge clk); while (!idle); // header fetch

      open_group();
      set_word(rec_addr(5) + VID_HEIGHT_OFFSET, 7);
      send_task(TT_GET_HEIGHT, 5, 'h11, 9, 'h123);
      wait_done();
      check_val("output tasks", outq.size(), 1);
      check_task(0, '{TT_PUSH, 9, 'h11, 7, 'h123});
      check_val("undo entries", undoq.size(), 0);
      check_val("memory writes", wr_count, 0);
      close_group("get_height");

      open_group();
      receive_case(5, 3, 10, 0, 4, 'h55);
      close_group("receive_wake");

      open_group();
      receive_case(6, 1, 20, 9, 5, 'h66);
      receive_case(SINK, 0, 3, 0, 7, 'h77);
      close_group("receive_quiet");

      open_group();
      set_word(rec_addr(6) + VID_HEIGHT_OFFSET, 3);
      send_task(TT_BFS, 5, 'h33, 1, 2);
      send_task(TT_GET_HEIGHT, 6, 'h44, 8, 'h99);
      wait_done();
      check_val("output tasks", outq.size(), 1);
      check_task(0, '{TT_PUSH, 8, 'h44, 3, 'h99});
      check_val("undo entries", undoq.size(), 0);
      check_val("memory writes", wr_count, 0);
      close_group("drop_bfs");

      open_group();
      out_delay_max = 24; // slow consumer so the FIFO fills
      for (int i = 0; i < 6; i++) set_word(rec_addr(10 + i) + VID_HEIGHT_OFFSET, 100 + i);
      for (int i = 0; i < 6; i++) send_task(TT_GET_HEIGHT, 10 + i, 'h500 + i, 20 + i, i);
      wait_done();
      check_val("output tasks", outq.size(), 6);
      for (int i = 0; i < 6; i++) check_task(i, '{TT_PUSH, 20 + i, 'h500 + i, 100 + i, i});
      assert (saw_full) else begin
         $display("FIFO never filled under back-pressure");
         errors++;
      end
      close_group("back_pressure");

      $display("summary: %0d of %0d groups ok, %0d errors", groups_ok, NUM_TESTS, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* maxflow_core.f */
maxflow_pkg.sv
task_intake.sv
task_fifo.sv
task_engine.sv
maxflow_core.sv
tb_graph_mem.sv
tb_maxflow_core.sv

/* Bender.yml */
package:
  name: maxflow_core

sources:
  - maxflow_pkg.sv
  - task_intake.sv
  - task_fifo.sv
  - task_engine.sv
  - maxflow_core.sv
  - target: test
    files:
      - tb_graph_mem.sv
      - tb_maxflow_core.sv
